// File: hdl/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Data and address width of the core
`define WORD_W 32

// Register address width, R0 to R15
`define REG_AW 4

// Byte step between sequential fetches
`define PC_STEP 4

// Pipeline view of R15 relative to the instruction address
`define R15_OFFSET 8

`endif

// File: hdl/pipePkg.sv
package pipePkg;

  // ALU operations
  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOpT;

  // Instruction class from bits 27:26
  typedef enum logic [1:0] {
    clsDataProc = 2'b00,
    clsMemory   = 2'b01,
    clsBranch   = 2'b10
  } instrClassT;

  // Immediate forms
  localparam logic [1:0] immRot8  = 2'b00;
  localparam logic [1:0] immOff12 = 2'b01;
  localparam logic [1:0] immBr24  = 2'b10;

  // Control fields carried down the pipeline, all zero is a bubble
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       aluSrcImm;
    logic       branch;
    aluOpT      aluOp;
    logic [1:0] immSrc;
    logic       addOffset;
  } ctrlT;

endpackage

// File: hdl/regfile.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module regfile (
  input  logic               clk,
  input  logic               we,
  input  logic [`REG_AW-1:0] ra1,
  input  logic [`REG_AW-1:0] ra2,
  input  logic [`REG_AW-1:0] wa,
  input  logic [`WORD_W-1:0] wd,
  input  logic [`WORD_W-1:0] r15,
  output logic [`WORD_W-1:0] rd1,
  output logic [`WORD_W-1:0] rd2
);

  logic [`WORD_W-1:0] regs [0:14];

  // Write on the falling edge so Decode sees it in the same cycle
  always_ff @(negedge clk) begin
    if (we && (wa != '1)) begin
      regs[wa] <= wd;
    end
  end

  // R15 comes from the PC, not the array
  assign rd1 = (ra1 == '1) ? r15 : regs[ra1];
  assign rd2 = (ra2 == '1) ? r15 : regs[ra2];

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module alu
  import pipePkg::*;
(
  input  logic [`WORD_W-1:0] a,
  input  logic [`WORD_W-1:0] b,
  input  aluOpT              op,
  input  logic               addOffset,
  output logic [`WORD_W-1:0] y
);

  logic               subtract;
  logic [`WORD_W-1:0] bIn;
  logic [`WORD_W-1:0] sum;

  // A set U bit always means an upward offset
  assign subtract = (op == aluSub) && !addOffset;

  // Shared adder for add, subtract and address generation
  assign bIn = subtract ? ~b : b;
  assign sum = a + bIn + {{(`WORD_W-1){1'b0}}, subtract};

  always_comb begin
    case (op)
      aluAnd:  y = a & b;
      aluOrr:  y = a | b;
      default: y = sum;
    endcase
  end

endmodule

// File: hdl/controller.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module controller
  import pipePkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [`WORD_W-1:0] instrD,
  input  logic               stallD,
  input  logic               flushE,
  output ctrlT               ctrlE,
  output ctrlT               ctrlM,
  output ctrlT               ctrlW
);

  ctrlT ctrlD;

  // Decode stage
  always_comb begin
    ctrlD = '0;
    case (instrClassT'(instrD[27:26]))
      clsDataProc: begin
        ctrlD.aluSrcImm = instrD[25];
        ctrlD.immSrc    = immRot8;
        ctrlD.regWrite  = 1'b1;
        case (instrD[24:21])
          4'b0100: ctrlD.aluOp = aluAdd;
          4'b0010: ctrlD.aluOp = aluSub;
          4'b0000: ctrlD.aluOp = aluAnd;
          4'b1100: ctrlD.aluOp = aluOrr;
          // Unsupported opcode becomes a bubble
          default: ctrlD.regWrite = 1'b0;
        endcase
      end
      clsMemory: begin
        // Immediate offset only, bit 25 clear
        if (!instrD[25]) begin
          ctrlD.aluSrcImm = 1'b1;
          ctrlD.immSrc    = immOff12;
          ctrlD.addOffset = instrD[23];
          ctrlD.aluOp     = instrD[23] ? aluAdd : aluSub;
          ctrlD.regWrite  = instrD[20];
          ctrlD.memToReg  = instrD[20];
          ctrlD.memWrite  = ~instrD[20];
        end
      end
      clsBranch: begin
        ctrlD.branch    = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.immSrc    = immBr24;
        ctrlD.aluOp     = aluAdd;
      end
      default: ctrlD = '0;
    endcase
  end

  // Execute register
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      ctrlE <= '0;
    end else if (!stallD) begin
      ctrlE <= ctrlD;
    end
  end

  // Memory and Writeback registers
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
    end
  end

endmodule

// File: hdl/hazardUnit.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module hazardUnit (
  input  logic [`REG_AW-1:0] ra1D,
  input  logic [`REG_AW-1:0] ra2D,
  input  logic [`REG_AW-1:0] ra1E,
  input  logic [`REG_AW-1:0] ra2E,
  input  logic [`REG_AW-1:0] waE,
  input  logic [`REG_AW-1:0] waM,
  input  logic [`REG_AW-1:0] waW,
  input  logic               regWriteM,
  input  logic               regWriteW,
  input  logic               memToRegE,
  input  logic               branchE,
  output logic [1:0]         forwardAE,
  output logic [1:0]         forwardBE,
  output logic               stallF,
  output logic               stallD,
  output logic               flushD,
  output logic               flushE
);

  logic loadStall;

  // 2'b10 Memory ALU output, 2'b01 Writeback result, 2'b00 register file
  function automatic logic [1:0] fwdSel(input logic [`REG_AW-1:0] ra);
    logic [1:0] sel;
    sel = 2'b00;
    if (regWriteM && (waM == ra) && (waM != '1)) begin
      sel = 2'b10;
    end else if (regWriteW && (waW == ra) && (waW != '1)) begin
      sel = 2'b01;
    end
    return sel;
  endfunction

  assign forwardAE = fwdSel(ra1E);
  assign forwardBE = fwdSel(ra2E);

  // Load result is not ready until Writeback
  assign loadStall = memToRegE && ((waE == ra1D) || (waE == ra2D));

  assign stallF = loadStall;
  assign stallD = loadStall;
  assign flushD = branchE;
  assign flushE = loadStall | branchE;

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module datapath
  import pipePkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [`WORD_W-1:0] instrF,
  input  logic [`WORD_W-1:0] readDataM,
  input  ctrlT               ctrlE,
  input  ctrlT               ctrlM,
  input  ctrlT               ctrlW,
  input  logic [1:0]         forwardAE,
  input  logic [1:0]         forwardBE,
  input  logic               stallF,
  input  logic               stallD,
  input  logic               flushD,
  input  logic               flushE,
  output logic [`WORD_W-1:0] pcF,
  output logic [`WORD_W-1:0] instrD,
  output logic [`WORD_W-1:0] aluOutM,
  output logic [`WORD_W-1:0] writeDataM,
  output logic               memWriteM,
  output logic [`REG_AW-1:0] ra1D,
  output logic [`REG_AW-1:0] ra2D,
  output logic [`REG_AW-1:0] ra1E,
  output logic [`REG_AW-1:0] ra2E,
  output logic [`REG_AW-1:0] waE,
  output logic [`REG_AW-1:0] waM,
  output logic [`REG_AW-1:0] waW
);

  // Class 2'b11 decodes to all-zero control
  localparam logic [`WORD_W-1:0] bubbleInstr = 32'h0C00_0000;

  logic [`WORD_W-1:0]   pcPlus4F, pcNextF;
  logic [`WORD_W-1:0]   pcD, r15D, rd1D, rd2D, rotImmD;
  logic [2*`WORD_W-1:0] rotPairD;
  logic                 isBranchD, isStoreD;
  logic [`WORD_W-1:0]   rd1E, rd2E, rotImmE, extImmE;
  logic [23:0]          imm24E;
  logic [`WORD_W-1:0]   srcAE, srcBE, writeDataE, aluResultE;
  logic [`WORD_W-1:0]   aluOutW, readDataW, resultW;

  // Fetch stage
  assign pcPlus4F = pcF + `PC_STEP;
  assign pcNextF  = ctrlE.branch ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // Decode stage
  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      instrD <= bubbleInstr;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      pcD <= pcF;
    end
  end

  assign isBranchD = instrClassT'(instrD[27:26]) == clsBranch;
  assign isStoreD  = (instrClassT'(instrD[27:26]) == clsMemory) && !instrD[20];

  // Branches use R15 as base, stores read Rd as data
  assign ra1D = isBranchD ? '1 : instrD[19:16];
  assign ra2D = isStoreD ? instrD[15:12] : instrD[3:0];
  assign r15D = pcD + `R15_OFFSET;

  regfile i_regfile (
    .clk (clk),
    .we  (ctrlW.regWrite),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa  (waW),
    .wd  (resultW),
    .r15 (r15D),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // imm8 rotated right by twice the rotate field
  assign rotPairD = {2{{(`WORD_W-8){1'b0}}, instrD[7:0]}} >> {instrD[11:8], 1'b0};
  assign rotImmD  = rotPairD[`WORD_W-1:0];

  // Execute stage
  always_ff @(posedge clk) begin
    if (!stallD) begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      rotImmE <= rotImmD;
      imm24E  <= instrD[23:0];
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      waE     <= instrD[15:12];
    end
  end

  always_comb begin
    case (ctrlE.immSrc)
      immOff12: extImmE = {{(`WORD_W-12){1'b0}}, imm24E[11:0]};
      immBr24:  extImmE = {{(`WORD_W-26){imm24E[23]}}, imm24E, 2'b00};
      default:  extImmE = rotImmE;
    endcase
  end

  // Forwarding muxes
  always_comb begin
    case (forwardAE)
      2'b01:   srcAE = resultW;
      2'b10:   srcAE = aluOutM;
      default: srcAE = rd1E;
    endcase
    case (forwardBE)
      2'b01:   writeDataE = resultW;
      2'b10:   writeDataE = aluOutM;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = ctrlE.aluSrcImm ? extImmE : writeDataE;

  alu i_alu (
    .a         (srcAE),
    .b         (srcBE),
    .op        (ctrlE.aluOp),
    .addOffset (ctrlE.addOffset),
    .y         (aluResultE)
  );

  // Memory stage
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    waM        <= waE;
  end

  assign memWriteM = ctrlM.memWrite;

  // Writeback stage
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    waW       <= waM;
  end

  assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

endmodule

// File: hdl/armPipe.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module armPipe
  import pipePkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [`WORD_W-1:0] instrF,
  input  logic [`WORD_W-1:0] readDataM,
  output logic [`WORD_W-1:0] pcF,
  output logic               memWriteM,
  output logic [`WORD_W-1:0] aluOutM,
  output logic [`WORD_W-1:0] writeDataM
);

  logic [`WORD_W-1:0] instrD;
  ctrlT               ctrlE, ctrlM, ctrlW;
  logic [1:0]         forwardAE, forwardBE;
  logic               stallF, stallD, flushD, flushE;
  logic [`REG_AW-1:0] ra1D, ra2D, ra1E, ra2E;
  logic [`REG_AW-1:0] waE, waM, waW;

  controller i_controller (
    .clk    (clk),
    .reset  (reset),
    .instrD (instrD),
    .stallD (stallD),
    .flushE (flushE),
    .ctrlE  (ctrlE),
    .ctrlM  (ctrlM),
    .ctrlW  (ctrlW)
  );

  datapath i_datapath (
    .clk        (clk),
    .reset      (reset),
    .instrF     (instrF),
    .readDataM  (readDataM),
    .ctrlE      (ctrlE),
    .ctrlM      (ctrlM),
    .ctrlW      (ctrlW),
    .forwardAE  (forwardAE),
    .forwardBE  (forwardBE),
    .stallF     (stallF),
    .stallD     (stallD),
    .flushD     (flushD),
    .flushE     (flushE),
    .pcF        (pcF),
    .instrD     (instrD),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM),
    .ra1D       (ra1D),
    .ra2D       (ra2D),
    .ra1E       (ra1E),
    .ra2E       (ra2E),
    .waE        (waE),
    .waM        (waM),
    .waW        (waW)
  );

  // Hazard checks use the control fields of the later stages
  hazardUnit i_hazardUnit (
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .waE       (waE),
    .waM       (waM),
    .waW       (waW),
    .regWriteM (ctrlM.regWrite),
    .regWriteW (ctrlW.regWrite),
    .memToRegE (ctrlE.memToReg),
    .branchE   (ctrlE.branch),
    .forwardAE (forwardAE),
    .forwardBE (forwardBE),
    .stallF    (stallF),
    .stallD    (stallD),
    .flushD    (flushD),
    .flushE    (flushE)
  );

endmodule

// File: verification/armPipe_assertions.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module armPipeAssertions (
  input logic               clk,
  input logic               reset,
  input logic [`WORD_W-1:0] pcF,
  input logic               memWriteM,
  input logic [`WORD_W-1:0] aluOutM
);

  // Count of failed assertions
  int failCount = 0;

  // Reset vector held
  property pcAtResetVector;
    @(posedge clk) reset |=> pcF == '0;
  endproperty

  property storeStrobeKnown;
    @(posedge clk) disable iff (reset) !$isunknown(memWriteM);
  endproperty

  property storeWordAligned;
    @(posedge clk) disable iff (reset) memWriteM |-> aluOutM[1:0] == 2'b00;
  endproperty

  // Sequential step, stall or branch target all move by whole words
  property pcWordStep;
    @(posedge clk) disable iff (reset)
      ((pcF - $past(pcF)) & 32'h3) == 32'h0;
  endproperty

  assert property (pcAtResetVector) else begin
    failCount++;
    $error("pcF is not zero during reset");
  end

  assert property (storeStrobeKnown) else begin
    failCount++;
    $error("memWriteM is unknown");
  end

  assert property (storeWordAligned) else begin
    failCount++;
    $error("store address is not word aligned");
  end

  assert property (pcWordStep) else begin
    failCount++;
    $error("pcF moved by a step that is not a word multiple");
  end

endmodule

bind armPipe armPipeAssertions i_assertions (
  .clk       (clk),
  .reset     (reset),
  .pcF       (pcF),
  .memWriteM (memWriteM),
  .aluOutM   (aluOutM)
);

// File: verification/armPipeTb.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module armPipeTb
  import pipePkg::*;
();

  localparam int randCount     = 40;
  localparam int sweepStart    = 10 + randCount;
  localparam int haltIdx       = sweepStart + 8;
  localparam int timeoutCycles = 2000;

  localparam logic [31:0] bubbleWord = 32'h0C00_0000;
  localparam logic [3:0]  opAdd      = 4'b0100;
  localparam logic [3:0]  opSub      = 4'b0010;
  localparam logic [3:0]  opAnd      = 4'b0000;
  localparam logic [3:0]  opOrr      = 4'b1100;

  logic               clk = 1'b0;
  logic               reset;
  logic [`WORD_W-1:0] instrF;
  logic [`WORD_W-1:0] readDataM;
  logic [`WORD_W-1:0] pcF;
  logic               memWriteM;
  logic [`WORD_W-1:0] aluOutM;
  logic [`WORD_W-1:0] writeDataM;

  logic [`WORD_W-1:0] imem [0:63];
  logic [`WORD_W-1:0] dmem [0:15];
  logic [`WORD_W-1:0] modelMem [0:15];
  logic [`WORD_W-1:0] modelRegs [0:15];
  logic [`WORD_W-1:0] expAddr [$];
  logic [`WORD_W-1:0] expData [$];
  logic [31:0]        lcgState;
  logic               monitorOn;
  int                 storesSeen;
  int                 expCount;

  armPipe i_dut (
    .clk        (clk),
    .reset      (reset),
    .instrF     (instrF),
    .readDataM  (readDataM),
    .pcF        (pcF),
    .memWriteM  (memWriteM),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM)
  );

  always #10 clk = ~clk;

  // Both memories answer combinationally
  assign instrF    = imem[pcF[7:2]];
  assign readDataM = dmem[aluOutM[5:2]];

  function automatic int unsigned randBelow(input int unsigned n);
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) % n;
  endfunction

  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
  endfunction

  // imm8 rotated right by twice the rotate field
  function automatic logic [31:0] rotImm(input logic [11:0] op2);
    logic [31:0] v;
    int          r;
    v = {24'h0, op2[7:0]};
    r = 2 * int'(op2[11:8]);
    return (v >> r) | (v << (32 - r));
  endfunction

  function automatic logic [3:0] dpOpcode(input int unsigned sel);
    logic [3:0] opc;
    case (sel)
      0:       opc = opAdd;
      1:       opc = opSub;
      2:       opc = opAnd;
      default: opc = opOrr;
    endcase
    return opc;
  endfunction

  function automatic logic [31:0] encDp(input logic [3:0] opc, input logic isImm,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [11:0] op2);
    return {4'hE, clsDataProc, isImm, opc, 1'b0, rn, rd, op2};
  endfunction

  // Pre-indexed word access, no writeback
  function automatic logic [31:0] encMem(input logic load, input logic up,
                                         input logic [3:0] rn, input logic [3:0] rd,
                                         input logic [11:0] off);
    return {4'hE, clsMemory, 1'b0, 1'b1, up, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] encBranch(input logic [23:0] off);
    return {4'hE, clsBranch, 1'b1, 1'b0, off};
  endfunction

  // R8 holds 0 for upward offsets, R9 holds 64 for downward ones
  function automatic logic [11:0] memOffset(input logic up);
    return up ? 12'(4 * randBelow(16)) : 12'(4 * (1 + randBelow(16)));
  endfunction

  function automatic logic [31:0] modelRead(input logic [3:0] r, input int pc);
    if (r == 4'hF) begin
      return 32'(pc * `PC_STEP + `R15_OFFSET);
    end
    return modelRegs[r];
  endfunction

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      reportFailure($sformatf("Mismatch in %s: expected %h, actual %h",
                              name, expected, actual));
    end
  endtask

  task automatic buildProgram();
    int          idx;
    int          skip;
    int unsigned kind;
    logic [3:0]  rd;
    logic [3:0]  rn;
    logic [3:0]  lastRd;
    logic [11:0] op2;
    logic        isImm;
    logic        up;
    for (int i = 0; i < 64; i++) begin
      imem[i] = bubbleWord;
    end
    // Seed R0 to R7 from R15 so no register starts unknown
    for (int r = 0; r < 8; r++) begin
      imem[r] = encDp(opAdd, 1'b1, 4'hF, 4'(r), 12'(randBelow(4096)));
    end
    imem[8] = encDp(opAnd, 1'b1, 4'hF, 4'h8, 12'h000);
    imem[9] = encDp(opAdd, 1'b1, 4'h8, 4'h9, 12'h040);
    lastRd  = 4'h7;
    for (int p = 0; p < randCount; p++) begin
      idx  = 10 + p;
      kind = randBelow(16);
      rd   = 4'(randBelow(8));
      rn   = (randBelow(2) == 0) ? lastRd : 4'(randBelow(8));
      up   = randBelow(2) == 0;
      if (kind < 8) begin
        // Half use the previous result as Rm, for back-to-back chains
        isImm     = randBelow(2) == 0;
        op2       = isImm ? 12'(randBelow(4096)) : {8'h00, lastRd};
        imem[idx] = encDp(dpOpcode(randBelow(4)), isImm, rn, rd, op2);
        lastRd    = rd;
      end else if (kind < 11) begin
        imem[idx] = encMem(1'b1, up, up ? 4'h8 : 4'h9, rd, memOffset(up));
        lastRd    = rd;
      end else if (kind < 14) begin
        rd        = (randBelow(8) == 0) ? 4'hF : lastRd;
        imem[idx] = encMem(1'b0, up, up ? 4'h8 : 4'h9, rd, memOffset(up));
      end else begin
        skip = 1 + int'(randBelow(3));
        skip = (p + skip >= randCount) ? randCount - 1 - p : skip;
        imem[idx] = encBranch(24'(skip - 1));
      end
    end
    for (int r = 0; r < 8; r++) begin
      imem[sweepStart + r] = encMem(1'b0, 1'b1, 4'h8, 4'(r), 12'(4 * r));
    end
    // Branch to itself
    imem[haltIdx] = encBranch(24'hFF_FFFE);
  endtask

  // Sequential ISA model, one instruction at a time
  task automatic runModel();
    int          pc;
    int          steps;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    for (int m = 0; m < 16; m++) begin
      modelMem[m]  = fillWord(32'(m * 4));
      modelRegs[m] = '0;
    end
    pc    = 0;
    steps = 0;
    while (pc != haltIdx && steps < 1000) begin
      instr = imem[pc];
      a     = modelRead(instr[19:16], pc);
      steps++;
      case (instr[27:26])
        2'b00: begin
          b = instr[25] ? rotImm(instr[11:0]) : modelRead(instr[3:0], pc);
          case (instr[24:21])
            opAdd:   res = a + b;
            opSub:   res = a - b;
            opAnd:   res = a & b;
            default: res = a | b;
          endcase
          modelRegs[instr[15:12]] = res;
          pc++;
        end
        2'b01: begin
          addr = instr[23] ? a + {20'h0, instr[11:0]} : a - {20'h0, instr[11:0]};
          if (instr[20]) begin
            modelRegs[instr[15:12]] = modelMem[addr[5:2]];
          end else begin
            expAddr.push_back(addr);
            expData.push_back(modelRead(instr[15:12], pc));
            modelMem[addr[5:2]] = modelRead(instr[15:12], pc);
          end
          pc++;
        end
        default: pc = pc + 2 + int'($signed(instr[23:0]));
      endcase
    end
    if (pc != haltIdx) begin
      reportFailure("The model never reached the halt loop");
    end
  endtask

  task automatic waitForStores();
    int cycles;
    cycles = 0;
    while (storesSeen < expCount && cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (storesSeen < expCount) begin
      reportFailure($sformatf("Timeout: only %0d of %0d expected stores arrived in %0d cycles",
                              storesSeen, expCount, timeoutCycles));
    end
  endtask

  // Watch the bound checker
  always @(posedge clk) begin
    if (i_dut.i_assertions.failCount != 0) begin
      reportFailure("An assertion in the bound checker failed");
    end
  end

  // Store monitor, mid-cycle where the Memory stage outputs are settled
  always @(negedge clk) begin
    logic [31:0] wantAddr;
    logic [31:0] wantData;
    if (reset) begin
      for (int m = 0; m < 16; m++) begin
        dmem[m] = fillWord(32'(m * 4));
      end
    end else if (monitorOn && memWriteM === 1'b1) begin
      if (expAddr.size() == 0) begin
        reportFailure("A store appeared after the expected store stream ended");
      end else begin
        wantAddr = expAddr.pop_front();
        wantData = expData.pop_front();
        checkValue($sformatf("store %0d address", storesSeen), wantAddr, aluOutM);
        checkValue($sformatf("store %0d data", storesSeen), wantData, writeDataM);
        dmem[aluOutM[5:2]] = writeDataM;
        storesSeen++;
      end
    end
  end

  initial begin
    reset      = 1'b1;
    monitorOn  = 1'b0;
    storesSeen = 0;
    lcgState   = 32'd62137;
    buildProgram();
    runModel();
    expCount = expAddr.size();
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      #1;
      checkValue("reset store strobe", 32'h0, {31'h0, memWriteM});
      checkValue("reset pc", 32'h0, pcF);
    end
    reset     = 1'b0;
    monitorOn = 1'b1;
    // Fetch leaves address 0 on the first edge out of reset
    @(posedge clk);
    #1;
    checkValue("second fetch", 32'(`PC_STEP), pcF);
    waitForStores();
    // Halt loop must stay quiet
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
    end
    if (storesSeen == expCount && expAddr.size() == 0 &&
        i_dut.i_assertions.failCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      reportFailure("The store count differs from the model or an assertion failed");
    end
  end

endmodule

// File: armPipe.f
+incdir+hdl
hdl/pipePkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/controller.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/armPipe.sv
verification/armPipe_assertions.sv
verification/armPipeTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := armPipeTb
FILELIST := armPipe.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
